//--- design/trdb_instr_pkg.sv
/* trace encoder instruction-side definitions
   retired-instruction record as seen by the filter and emitter */

package trdb_instr_pkg;

    localparam int unsigned XLEN = 32; // instruction address width

    // retired instruction class, only branches feed the branch map
    typedef enum logic [1:0] {
        ITYPE_OTHER = 2'b00, // anything that is not a conditional branch
        ITYPE_BR_NT = 2'b01, // conditional branch, not taken
        ITYPE_BR_T  = 2'b10  // conditional branch, taken
    } trdb_itype_e;

    // one retired instruction per cycle at most
    typedef struct packed {
        logic             valid; // record present this cycle
        logic [XLEN-1:0]  iaddr; // address of the retired instruction
        trdb_itype_e      itype; // instruction class
    } trdb_instr_t;

endpackage

//--- design/trdb_pkt_pkg.sv
/* trace encoder packet-side definitions
   packet kinds, payload views, branch map sizing and resync defaults */

package trdb_pkt_pkg;

    localparam int unsigned BMAP_LEN = 8; // branch outcomes per branch packet
    localparam int unsigned BCNT_W   = 4; // holds 0..BMAP_LEN
    localparam int unsigned PAD_W    = trdb_instr_pkg::XLEN - BCNT_W - BMAP_LEN;

    // what the resync counter advances on
    typedef enum logic {
        RESYNC_PACKET = 1'b0, // one step per emitted packet
        RESYNC_CYCLE  = 1'b1  // one step per traced cycle
    } trdb_resync_mode_e;

    localparam trdb_resync_mode_e RESYNC_MODE_DEF = RESYNC_PACKET;
    localparam int unsigned       RESYNC_MAX_DEF  = 16; // steps between forced syncs

    typedef enum logic {
        PKT_SYNC   = 1'b0, // full address
        PKT_BRANCH = 1'b1  // taken/not-taken map
    } trdb_pkt_kind_e;

    // sync view, whole word is the address
    typedef struct packed {
        logic [trdb_instr_pkg::XLEN-1:0] address;
    } trdb_sync_view_t;

    // branch view, map in the low bits, first branch at bit 0
    typedef struct packed {
        logic [PAD_W-1:0]    pad;   // always zero
        logic [BCNT_W-1:0]   count; // valid bits in map, 1..BMAP_LEN
        logic [BMAP_LEN-1:0] map;   // 1 = taken
    } trdb_branch_view_t;

    // same payload word, decoded by kind
    typedef union packed {
        trdb_sync_view_t   sync;
        trdb_branch_view_t branch;
    } trdb_payload_u;

    typedef struct packed {
        trdb_pkt_kind_e kind;    // selects the payload view
        trdb_payload_u  payload; // sync address or branch map
    } trdb_pkt_t;

endpackage

//--- design/trdb_filter.sv
/* address-range filter
   marks traced instructions and single-cycle range entry and exit */

`timescale 1ns/100ps

module trdb_filter (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  trdb_instr_pkg::trdb_instr_t        instr_i,
    input  logic [trdb_instr_pkg::XLEN-1:0]    range_lo_i, // inclusive
    input  logic [trdb_instr_pkg::XLEN-1:0]    range_hi_i, // inclusive
    output logic                               traced_o,
    output logic                               tracing_o,
    output logic                               enter_o,
    output logic                               exit_o
);

    logic in_range;  // address compare, ignores valid
    logic tracing_q; // last valid instruction was in range

    // static bounds, both ends included
    assign in_range = (instr_i.iaddr >= range_lo_i) && (instr_i.iaddr <= range_hi_i);

    assign traced_o  = instr_i.valid && in_range;
    assign tracing_o = tracing_q;

    // entry: first traced one after an out-of-range stretch
    assign enter_o = traced_o && !tracing_q;

    // exit: first valid out-of-range one while tracing
    assign exit_o = instr_i.valid && !in_range && tracing_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tracing_q <= 1'b0;  // start outside the range
        end else if (instr_i.valid) begin
            tracing_q <= in_range; // idle cycles keep the state
        end
    end

endmodule

//--- design/trdb_resync_counter.sv
/* resync counter
   counts packets or traced cycles, raises a sticky resync-due flag at threshold */

`timescale 1ns/100ps

module trdb_resync_counter #(
    parameter trdb_pkt_pkg::trdb_resync_mode_e MODE       = trdb_pkt_pkg::RESYNC_MODE_DEF,
    parameter int unsigned                     RESYNC_MAX = trdb_pkt_pkg::RESYNC_MAX_DEF
) (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic tracing_i,        // from filter
    input  logic packet_emitted_i, // registered packet strobe
    input  logic resync_clr_i,     // emitter sent a sync
    output logic resync_due_o
);

    import trdb_pkt_pkg::*;

    localparam int unsigned CNT_W = $clog2(RESYNC_MAX + 1); // must hold RESYNC_MAX itself

    logic [CNT_W-1:0] count_q;
    logic             count_en;
    logic             at_max;
    logic             due_q;

    // event source picked at elaboration
    assign count_en = (MODE == RESYNC_PACKET) ? packet_emitted_i : tracing_i;

    assign at_max = (count_q == CNT_W'(RESYNC_MAX));

    assign resync_due_o = due_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q <= '0;
        end else if (resync_clr_i) begin
            count_q <= '0;  // clear beats increment
        end else if (count_en && !at_max) begin
            count_q <= count_q + CNT_W'(1); // saturate at threshold
        end
    end

    // flag lags the count by one cycle, holds until cleared
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            due_q <= 1'b0;
        end else if (resync_clr_i) begin
            due_q <= 1'b0;
        end else if (at_max) begin
            due_q <= 1'b1;
        end
    end

endmodule

//--- design/trdb_branch_map.sv
/* branch map
   collects taken/not-taken outcomes, first branch in bit 0,
   and exposes next-state contents so a full map can be packed at once */

`timescale 1ns/100ps

module trdb_branch_map (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                push_i,  // traced branch to record
    input  logic                                taken_i, // outcome of that branch
    input  logic                                clear_i, // drops map and any push
    output logic [trdb_pkt_pkg::BMAP_LEN-1:0]   bits_o,
    output logic [trdb_pkt_pkg::BCNT_W-1:0]     count_o,
    output logic [trdb_pkt_pkg::BMAP_LEN-1:0]   bits_next_o,
    output logic [trdb_pkt_pkg::BCNT_W-1:0]     count_next_o,
    output logic                                full_o
);

    import trdb_pkt_pkg::*;

    logic [BMAP_LEN-1:0] bits_q;
    logic [BCNT_W-1:0]   count_q;
    logic [BMAP_LEN-1:0] taken_bit; // outcome moved to its slot

    // slot index is the current count
    assign taken_bit = {{(BMAP_LEN-1){1'b0}}, taken_i} << count_q;

    always_comb begin
        bits_next_o  = bits_q;
        count_next_o = count_q;
        if (push_i) begin
            bits_next_o  = bits_q | taken_bit; // not-taken leaves a zero
            count_next_o = count_q + BCNT_W'(1);
        end
    end

    // this push fills the last slot
    assign full_o = push_i && (count_q == BCNT_W'(BMAP_LEN - 1));

    assign bits_o  = bits_q;
    assign count_o = count_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            bits_q  <= '0;
            count_q <= '0;
        end else if (clear_i) begin
            bits_q  <= '0;  // same-cycle push is lost
            count_q <= '0;
        end else begin
            bits_q  <= bits_next_o;
            count_q <= count_next_o;
        end
    end

endmodule

//--- design/trdb_packet_emitter.sv
/* packet emitter
   picks sync, full-map or flush packet per instruction and registers it,
   so each packet leaves one cycle after its instruction */

`timescale 1ns/100ps

module trdb_packet_emitter (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  trdb_instr_pkg::trdb_instr_t         instr_i,
    input  logic                                traced_i,
    input  logic                                enter_i,
    input  logic                                exit_i,
    input  logic                                resync_due_i,
    input  logic [trdb_pkt_pkg::BMAP_LEN-1:0]   bits_i,
    input  logic [trdb_pkt_pkg::BCNT_W-1:0]     count_i,
    input  logic [trdb_pkt_pkg::BMAP_LEN-1:0]   bits_next_i,
    input  logic [trdb_pkt_pkg::BCNT_W-1:0]     count_next_i,
    input  logic                                full_i,
    output logic                                push_o,
    output logic                                taken_o,
    output logic                                map_clr_o,
    output logic                                resync_clr_o,
    output logic                                pkt_valid_o,
    output trdb_pkt_pkg::trdb_pkt_t             pkt_o
);

    import trdb_instr_pkg::*;
    import trdb_pkt_pkg::*;

    logic          is_branch;
    logic          emit_sync;   // rule 1
    logic          emit_full;   // rule 2
    logic          emit_flush;  // rule 3
    logic          pkt_valid_d;
    trdb_pkt_t     pkt_d;
    logic          pkt_valid_q;
    trdb_pkt_t     pkt_q;

    assign is_branch = (instr_i.itype == ITYPE_BR_T) || (instr_i.itype == ITYPE_BR_NT);

    // entry or due resync wins over everything
    assign emit_sync = traced_i && (enter_i || resync_due_i);

    // branch consumed by a sync is never recorded
    assign push_o  = traced_i && is_branch && !emit_sync;
    assign taken_o = (instr_i.itype == ITYPE_BR_T);

    // full only comes with a push, so sync is already excluded
    assign emit_full = full_i;

    // leaving the range with pending bits, exit never overlaps traced
    assign emit_flush = exit_i && (count_i != '0);

    assign pkt_valid_d  = emit_sync || emit_full || emit_flush;
    assign map_clr_o    = pkt_valid_d; // every packet empties the map
    assign resync_clr_o = emit_sync;

    always_comb begin
        pkt_d         = '0;
        pkt_d.kind    = PKT_BRANCH;
        if (emit_sync) begin
            pkt_d.kind                   = PKT_SYNC;
            pkt_d.payload.sync.address   = instr_i.iaddr;
        end else if (emit_full) begin
            pkt_d.payload.branch.map     = bits_next_i;  // includes this branch
            pkt_d.payload.branch.count   = count_next_i;
        end else begin
            pkt_d.payload.branch.map     = bits_i;       // flush, pending bits only
            pkt_d.payload.branch.count   = count_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pkt_valid_q <= 1'b0;
        end else begin
            pkt_valid_q <= pkt_valid_d; // one-cycle strobe
        end
    end

    // payload only loads with a packet
    always_ff @(posedge clk_i) begin
        if (pkt_valid_d) begin
            pkt_q <= pkt_d;
        end
    end

    assign pkt_valid_o = pkt_valid_q;
    assign pkt_o       = pkt_q;

endmodule

//--- design/trdb_encoder.sv
/* instruction trace encoder top
   filter, resync counter, branch map and packet emitter */

`timescale 1ns/100ps

module trdb_encoder (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  trdb_instr_pkg::trdb_instr_t        instr_i,
    input  logic [trdb_instr_pkg::XLEN-1:0]    range_lo_i,
    input  logic [trdb_instr_pkg::XLEN-1:0]    range_hi_i,
    output logic                               pkt_valid_o,
    output trdb_pkt_pkg::trdb_pkt_t            pkt_o
);

    import trdb_pkt_pkg::*;

    logic                traced;     // in range this cycle
    logic                tracing;    // range state
    logic                enter;
    logic                leave;
    logic                resync_due;
    logic                resync_clr;
    logic                push;
    logic                taken;
    logic                map_clr;
    logic                map_full;
    logic [BMAP_LEN-1:0] bits;
    logic [BCNT_W-1:0]   count;
    logic [BMAP_LEN-1:0] bits_next;
    logic [BCNT_W-1:0]   count_next;

    trdb_filter u_filter (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .instr_i    (instr_i),
        .range_lo_i (range_lo_i),
        .range_hi_i (range_hi_i),
        .traced_o   (traced),
        .tracing_o  (tracing),
        .enter_o    (enter),
        .exit_o     (leave)
    );

    // package defaults for mode and threshold
    trdb_resync_counter u_resync (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .tracing_i        (tracing),
        .packet_emitted_i (pkt_valid_o),
        .resync_clr_i     (resync_clr),
        .resync_due_o     (resync_due)
    );

    trdb_branch_map u_bmap (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .push_i       (push),
        .taken_i      (taken),
        .clear_i      (map_clr),
        .bits_o       (bits),
        .count_o      (count),
        .bits_next_o  (bits_next),
        .count_next_o (count_next),
        .full_o       (map_full)
    );

    trdb_packet_emitter u_emit (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .instr_i      (instr_i),
        .traced_i     (traced),
        .enter_i      (enter),
        .exit_i       (leave),
        .resync_due_i (resync_due),
        .bits_i       (bits),
        .count_i      (count),
        .bits_next_i  (bits_next),
        .count_next_i (count_next),
        .full_i       (map_full),
        .push_o       (push),
        .taken_o      (taken),
        .map_clr_o    (map_clr),
        .resync_clr_o (resync_clr),
        .pkt_valid_o  (pkt_valid_o),
        .pkt_o        (pkt_o)
    );

endmodule

//--- tests/trdb_encoder_props.sv
/* trace encoder port properties
   quiet reset, packet causality and branch count range */

`timescale 1ns/100ps

module trdb_encoder_props (
    input logic                        clk_i,
    input logic                        rst_ni,
    input trdb_instr_pkg::trdb_instr_t instr_i,
    input logic                        pkt_valid_i,
    input trdb_pkt_pkg::trdb_pkt_t     pkt_i
);

    import trdb_pkt_pkg::*;

    logic is_branch_pkt; // strobe with branch kind

    assign is_branch_pkt = pkt_valid_i && (pkt_i.kind == PKT_BRANCH);

    // nothing leaves while reset is held
    a_quiet_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !pkt_valid_i)
        else $error("packet strobe high during reset");

    // each packet comes from an instruction one cycle earlier
    a_pkt_has_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pkt_valid_i |-> $past(instr_i.valid))
        else $error("packet without a valid instruction in the previous cycle");

    // flush needs pending bits, a full map has exactly BMAP_LEN
    a_branch_count: assert property (@(posedge clk_i) disable iff (!rst_ni)
        is_branch_pkt |-> (pkt_i.payload.branch.count != '0) &&
                          (pkt_i.payload.branch.count <= BCNT_W'(BMAP_LEN)))
        else $error("branch packet count out of range");

endmodule

bind trdb_encoder trdb_encoder_props u_props (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .instr_i     (instr_i),
    .pkt_valid_i (pkt_valid_o),
    .pkt_i       (pkt_o)
);

//--- tests/tb_trdb_encoder.sv
/* testbench for the instruction trace encoder
   directed and random instruction streams checked against a reference model */

`timescale 1ns/100ps

module tb_trdb_encoder;

    import trdb_instr_pkg::*;
    import trdb_pkt_pkg::*;

    localparam logic [XLEN-1:0] RANGE_LO   = 32'h0000_1000;
    localparam logic [XLEN-1:0] RANGE_HI   = 32'h0000_1FFF;
    localparam int unsigned     N_INSTR    = 445; // 5 + 8 + 5 + 125 + 300 + 2 drain
    localparam int unsigned     MAX_CYCLES = (N_INSTR + 100) * 2;

    logic            clk_i;
    logic            rst_ni;
    trdb_instr_t     instr;
    logic [XLEN-1:0] range_lo;
    logic [XLEN-1:0] range_hi;
    logic            pkt_valid;
    trdb_pkt_t       pkt;

    logic                m_tracing;    // model range state
    logic [BMAP_LEN-1:0] m_bits;       // model branch map
    logic [BCNT_W-1:0]   m_cnt;
    int unsigned         m_rcnt;       // model resync count
    logic                m_due;
    logic                m_strobe;     // model packet leaving this cycle
    trdb_pkt_t           pred_q[$];    // predicted packets in order
    trdb_pkt_t           hand_pkt;     // directed expectation
    logic                hand_pending;
    int unsigned         err_cnt;
    int unsigned         cycles;
    logic [31:0]         rng;

    trdb_encoder dut0 (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .instr_i     (instr),
        .range_lo_i  (range_lo),
        .range_hi_i  (range_hi),
        .pkt_valid_o (pkt_valid),
        .pkt_o       (pkt)
    );

    always #2 clk_i = ~clk_i; // 4 ns period

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: no verdict after %0d clock cycles", cycles);
            $display("test failed");
            $fatal(1, "run limit reached");
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic trdb_pkt_t sync_pkt(input logic [XLEN-1:0] addr);
        trdb_pkt_t p;
        p = '0;
        p.kind = PKT_SYNC;
        p.payload.sync.address = addr;
        return p;
    endfunction

    function automatic trdb_pkt_t branch_pkt(input logic [BMAP_LEN-1:0] map,
                                             input logic [BCNT_W-1:0] cnt);
        trdb_pkt_t p;
        p = '0;
        p.kind = PKT_BRANCH;
        p.payload.branch.map   = map;
        p.payload.branch.count = cnt;
        return p;
    endfunction

    task automatic stop_on_mismatch(input string msg);
        err_cnt++;
        $display("Fail @ %0t ns: %s", $time, msg);
        $display("test failed");
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic check_valid(input logic want);
        if (pkt_valid !== want) begin
            stop_on_mismatch($sformatf("pkt_valid_o is %b, expected %b", pkt_valid, want));
        end
    endtask

    task automatic check_pkt(input trdb_pkt_t want);
        if (pkt !== want) begin
            stop_on_mismatch($sformatf("packet kind %0d payload %h, expected kind %0d payload %h",
                                       pkt.kind, pkt.payload, want.kind, want.payload));
        end
    endtask

    // outputs now belong to the instruction of the previous cycle
    task automatic compare_cycle();
        trdb_pkt_t want;
        check_valid(m_strobe);
        if (m_strobe) begin
            want = pred_q.pop_front();
            check_pkt(want);
        end
        if (hand_pending) begin
            check_valid(1'b1);
            check_pkt(hand_pkt);
            hand_pending = 1'b0;
        end
    endtask

    // emitter priority and counter rules for one cycle
    task automatic model_step(input trdb_instr_t rec);
        logic                in_rng, traced, enter, leave, sync, push, full, flush;
        logic [BMAP_LEN-1:0] nbits;
        logic [BCNT_W-1:0]   ncnt;
        in_rng = (rec.iaddr >= RANGE_LO) && (rec.iaddr <= RANGE_HI);
        traced = rec.valid && in_rng;
        enter  = traced && !m_tracing;
        leave  = rec.valid && !in_rng && m_tracing;
        sync   = traced && (enter || m_due);
        push   = traced && (rec.itype != ITYPE_OTHER) && !sync; // sync eats the branch
        nbits  = m_bits;
        ncnt   = m_cnt;
        if (push) begin
            nbits[m_cnt[2:0]] = (rec.itype == ITYPE_BR_T); // first branch in bit 0
            ncnt = m_cnt + 1'b1;
        end
        full  = push && (ncnt == BCNT_W'(BMAP_LEN));
        flush = leave && (m_cnt != '0);
        if (sync) begin
            pred_q.push_back(sync_pkt(rec.iaddr));
        end else if (full) begin
            pred_q.push_back(branch_pkt(nbits, ncnt));
        end else if (flush) begin
            pred_q.push_back(branch_pkt(m_bits, m_cnt));
        end
        if (sync) begin
            m_due = 1'b0;
        end else if (m_rcnt == RESYNC_MAX_DEF) begin
            m_due = 1'b1; // one cycle behind the count
        end
        if (sync) begin
            m_rcnt = 0;
        end else if (m_strobe && (m_rcnt < RESYNC_MAX_DEF)) begin
            m_rcnt++;
        end
        if (sync || full || flush) begin
            m_bits = '0;
            m_cnt  = '0;
        end else if (push) begin
            m_bits = nbits;
            m_cnt  = ncnt;
        end
        if (rec.valid) begin
            m_tracing = in_rng;
        end
        m_strobe = sync || full || flush;
    endtask

    task automatic drive_instr(input logic valid, input logic [XLEN-1:0] addr,
                               input trdb_itype_e itype);
        trdb_instr_t rec;
        rec.valid = valid;
        rec.iaddr = addr;
        rec.itype = itype;
        @(negedge clk_i);
        compare_cycle();
        instr = rec;
        model_step(rec);
    endtask

    task automatic note_expected(input trdb_pkt_t p);
        hand_pkt     = p;
        hand_pending = 1'b1;
    endtask

    task automatic test_sync_on_entry();
        drive_instr(1'b1, 32'h0000_0800, ITYPE_OTHER);
        drive_instr(1'b1, 32'h0000_2000, ITYPE_BR_T); // just above range
        drive_instr(1'b1, 32'h0000_0FFF, ITYPE_OTHER); // just below
        drive_instr(1'b1, 32'h0000_1000, ITYPE_OTHER);
        note_expected(sync_pkt(32'h0000_1000));
        drive_instr(1'b1, 32'h0000_1004, ITYPE_OTHER);
    endtask

    task automatic test_full_map();
        logic [BMAP_LEN-1:0] outcomes;
        outcomes = 8'b1011_0010;
        for (int i = 0; i < 8; i++) begin
            drive_instr(1'b1, 32'h0000_1008 + 32'(4 * i),
                        outcomes[i] ? ITYPE_BR_T : ITYPE_BR_NT);
        end
        note_expected(branch_pkt(outcomes, 4'd8));
    endtask

    task automatic test_flush_and_reenter();
        drive_instr(1'b1, 32'h0000_1040, ITYPE_BR_T);
        drive_instr(1'b1, 32'h0000_1044, ITYPE_BR_NT);
        drive_instr(1'b1, 32'h0000_1048, ITYPE_BR_T);
        drive_instr(1'b1, 32'h0000_4000, ITYPE_OTHER); // leaves with 3 pending
        note_expected(branch_pkt(8'b0000_0101, 4'd3));
        drive_instr(1'b1, 32'h0000_1100, ITYPE_OTHER);
        note_expected(sync_pkt(32'h0000_1100));
    endtask

    // 1 sync and 15 full maps reach the threshold and 2 pending bits are dropped
    task automatic test_periodic_resync();
        drive_instr(1'b1, 32'h0000_3000, ITYPE_OTHER);
        drive_instr(1'b1, 32'h0000_1200, ITYPE_OTHER);
        note_expected(sync_pkt(32'h0000_1200));
        for (int i = 0; i < 120; i++) begin
            rng = xorshift(rng);
            drive_instr(1'b1, 32'h0000_1204, rng[0] ? ITYPE_BR_T : ITYPE_BR_NT);
        end
        drive_instr(1'b1, 32'h0000_1208, ITYPE_BR_T);
        drive_instr(1'b1, 32'h0000_120C, ITYPE_BR_NT);
        drive_instr(1'b1, 32'h0000_1800, ITYPE_OTHER); // mid-range with due set
        note_expected(sync_pkt(32'h0000_1800));
    endtask

    task automatic test_random_stream();
        logic [XLEN-1:0] addr;
        trdb_itype_e     itype;
        for (int i = 0; i < 300; i++) begin
            rng = xorshift(rng);
            case (rng[5:4])
                2'd0:    addr = rng[6] ? 32'h0000_2000 : 32'h0000_0FFF;
                2'd1:    addr = {rng[31:16], 16'h8000}; // far above
                default: addr = {20'h00001, rng[13:2]}; // inside
            endcase
            case (rng[9:8])
                2'd0:    itype = ITYPE_OTHER;
                2'd1:    itype = ITYPE_BR_NT;
                default: itype = ITYPE_BR_T;
            endcase
            drive_instr(rng[12:10] != 3'b000, addr, itype);
        end
    endtask

    initial begin
        clk_i        = 1'b0;
        rst_ni       = 1'b1;
        instr        = '0;
        range_lo     = RANGE_LO;
        range_hi     = RANGE_HI;
        m_tracing    = 1'b0;
        m_bits       = '0;
        m_cnt        = '0;
        m_rcnt       = 0;
        m_due        = 1'b0;
        m_strobe     = 1'b0;
        hand_pkt     = '0;
        hand_pending = 1'b0;
        err_cnt      = 0;
        cycles       = 0;
        rng          = 32'd60;
        #1 rst_ni = 1'b0;
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        test_sync_on_entry();
        test_full_map();
        test_flush_and_reenter();
        test_periodic_resync();
        test_random_stream();
        drive_instr(1'b0, '0, ITYPE_OTHER); // drain the last packet
        drive_instr(1'b0, '0, ITYPE_OTHER);
        if (pred_q.size() != 0) begin
            stop_on_mismatch("predicted packets never appeared on the output");
        end
        if (err_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- flist.f
design/trdb_instr_pkg.sv
design/trdb_pkt_pkg.sv
design/trdb_filter.sv
design/trdb_resync_counter.sv
design/trdb_branch_map.sv
design/trdb_packet_emitter.sv
design/trdb_encoder.sv
tests/trdb_encoder_props.sv
tests/tb_trdb_encoder.sv

//--- run.sh
#!/bin/sh
# build the trace encoder testbench with Verilator, run it, grep the log for the verdict
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps -f flist.f \
    --top-module tb_trdb_encoder -o tb_trdb_encoder > build.log 2>&1 \
    && { ./obj_dir/tb_trdb_encoder > sim.log 2>&1 || true; } \
    || { cat build.log; echo "build error"; exit 1; }
grep -qx "test passed" sim.log \
    && { echo "PASS"; exit 0; } \
    || { cat sim.log; echo "FAIL"; exit 1; }
